// File: hw/burstCounter.sv
`timescale 1ns/1ns

module burstCounter import mboxClkPkg::*; (
  input  logic        MBOX_CLK,
  input  logic        CLK,
  input  funcStrobe_s strobe,
  input  ebusData_t   ldData,
  input  logic        pulse,
  output burstCount_t burstCount,
  output logic        burstZero
);

  assign burstZero = burstCount == '0;

  // Nibble loads take priority over the count
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      burstCount <= '0;
    end else if (strobe.ldBurstLo) begin
      // Function 042
      burstCount[3:0] <= ldData[3:0];
    end else if (strobe.ldBurstHi) begin
      // Function 043
      burstCount[7:4] <= ldData[3:0];
    end else if (pulse && !burstZero) begin
      // One down per issued pulse, holds at zero
      burstCount <= burstCount - 8'd1;
    end
  end

endmodule

// File: hw/clkConfigRegs.sv
`timescale 1ns/1ns

module clkConfigRegs import mboxClkPkg::*; (
  input  logic        MBOX_CLK,
  input  logic        CLK,
  input  funcStrobe_s strobe,
  input  ebusData_t   ldData,
  output rateSel_t    rateSel,
  output logic        crmDis,
  output logic        edpDis,
  output logic        ctlDis
);

  // Function 044, rate in the low two data bits
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateSel <= '0;
    end else if (strobe.ldRate) begin
      rateSel <= ldData[1:0];
    end
  end

  // Function 045, one disable per EBOX clock group
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
    end else if (strobe.ldDisable) begin
      // CRAM group
      crmDis <= ldData[2];
      // EDP group
      edpDis <= ldData[1];
      // CTL group
      ctlDis <= ldData[0];
    end
  end

endmodule

// File: hw/diagFuncDecoder.sv
`timescale 1ns/1ns

module diagFuncDecoder import mboxClkPkg::*; (
  input  logic        MBOX_CLK,
  input  logic        CLK,
  input  diagCmd_s    cmd,
  input  logic        cmdValid,
  output logic        cmdReady,
  input  logic        rspBusy,
  output funcStrobe_s strobe,
  output ebusData_t   ldData,
  output logic        readReq,
  output diagSel_t    readSel
);

  logic        accept;
  funcStrobe_s nextStrobe;

  // Hold off while a read is in flight or its word is unconsumed
  assign cmdReady = ~(rspBusy | readReq);
  assign accept   = cmdValid & cmdReady;

  always_comb begin
    nextStrobe = '0;
    if (accept && cmd.cmdClass == ctlFunc) begin
      // EBOX SS and cond SS (011, 100) fall through
      case (cmd.sel)
        ctlStop:       nextStrobe.stop       = 1'b1;
        ctlStart:      nextStrobe.start      = 1'b1;
        ctlSingleStep: nextStrobe.singleStep = 1'b1;
        ctlBurst:      nextStrobe.burst      = 1'b1;
        ctlSetReset:   nextStrobe.setReset   = 1'b1;
        ctlClrReset:   nextStrobe.clrReset   = 1'b1;
        default:       nextStrobe            = '0;
      endcase
    end else if (accept && cmd.cmdClass == ldFunc) begin
      // 040, 041, 046, 047 accepted, no effect
      case (cmd.sel)
        ldBurstLoSel: nextStrobe.ldBurstLo = 1'b1;
        ldBurstHiSel: nextStrobe.ldBurstHi = 1'b1;
        ldRateSel:    nextStrobe.ldRate    = 1'b1;
        ldDisableSel: nextStrobe.ldDisable = 1'b1;
        default:      nextStrobe           = '0;
      endcase
    end
  end

  // Strobes last exactly one cycle
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      strobe  <= '0;
      readReq <= 1'b0;
    end else begin
      strobe  <= nextStrobe;
      readReq <= accept && cmd.cmdClass == readFunc;
    end
  end

  // Payload follows the accepted command
  always_ff @(posedge MBOX_CLK) begin
    if (accept) begin
      ldData  <= cmd.data;
      readSel <= cmd.sel;
    end
  end

endmodule

// File: hw/diagReadback.sv
`timescale 1ns/1ns

module diagReadback import mboxClkPkg::*; (
  input  logic       MBOX_CLK,
  input  logic       CLK,
  input  logic       readReq,
  input  diagSel_t   readSel,
  input  clkStatus_s status,
  output ebusData_t  rspData,
  output logic       rspValid,
  input  logic       rspReady
);

  ebusData_t statusWord;

  // Status map on EBUS bits 30..35
  always_comb begin
    case (readSel)
      3'd0: statusWord = {status.mrReset, status.burstActive,
                          status.runActive, 1'b0, status.rateSel};
      // Count MSBs
      3'd1: statusWord = status.burstCount[7:2];
      // Count LSBs, then group disables
      3'd2: statusWord = {status.burstCount[1:0], 1'b0,
                          status.crmDis, status.edpDis, status.ctlDis};
      default: statusWord = '0;
    endcase
  end

  // Valid holds until the response transfers
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rspValid <= 1'b0;
    end else if (readReq) begin
      rspValid <= 1'b1;
    end else if (rspValid && rspReady) begin
      rspValid <= 1'b0;
    end
  end

  // Word sampled once per read, stable while held
  always_ff @(posedge MBOX_CLK) begin
    if (readReq) begin
      rspData <= statusWord;
    end
  end

endmodule

// File: hw/eboxClkGate.sv
`timescale 1ns/1ns

module eboxClkGate import mboxClkPkg::*; (
  input  logic        MBOX_CLK,
  input  logic        CLK,
  input  funcStrobe_s strobe,
  input  rateSel_t    rateSel,
  input  logic        crmDis,
  input  logic        edpDis,
  input  logic        ctlDis,
  input  logic        burstZero,
  output logic        pulse,
  output logic        crmClkEn,
  output logic        edpClkEn,
  output logic        ctlClkEn,
  output logic        runActive,
  output logic        burstActive,
  output logic        mrReset
);

  gateState_e state;
  logic [2:0] divCnt;
  logic [2:0] divMask;
  logic       tick;
  logic       goStrobe;

  // Period 2**rateSel, tick when masked bits are zero
  assign divMask  = 3'((4'd1 << rateSel) - 4'd1);
  assign tick     = (divCnt & divMask) == 3'd0;
  assign goStrobe = strobe.start | strobe.singleStep | strobe.burst;

  // No burst pulse once the count has run out
  always_comb begin
    case (state)
      gateRunning: pulse = tick;
      gateStep:    pulse = tick;
      gateBurst:   pulse = tick & ~burstZero;
      default:     pulse = 1'b0;
    endcase
  end

  assign crmClkEn    = pulse & ~crmDis;
  assign edpClkEn    = pulse & ~edpDis;
  assign ctlClkEn    = pulse & ~ctlDis;
  assign runActive   = state == gateRunning;
  assign burstActive = state == gateBurst;

  // Divider restarts so the first pulse follows the strobe directly
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      divCnt <= '0;
    end else if (goStrobe) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 3'd1;
    end
  end

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      state <= gateStopped;
    end else if (strobe.stop) begin
      state <= gateStopped;
    end else if (strobe.start) begin
      state <= gateRunning;
    end else if (strobe.singleStep) begin
      state <= gateStep;
    end else if (strobe.burst && !burstZero) begin
      state <= gateBurst;
    end else if (state == gateStep && pulse) begin
      // One pulse and done
      state <= gateStopped;
    end else if (state == gateBurst && burstZero) begin
      state <= gateStopped;
    end
  end

  // MR RESET, set at power-up
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b1;
    end else if (strobe.setReset) begin
      mrReset <= 1'b1;
    end else if (strobe.clrReset) begin
      mrReset <= 1'b0;
    end
  end

endmodule

// File: hw/mboxClkPkg.sv
package mboxClkPkg;

  // Field widths with a meaning of their own
  typedef logic [2:0] diagSel_t;
  // EBUS bits 30 to 35
  typedef logic [5:0] ebusData_t;
  typedef logic [7:0] burstCount_t;
  // Pulse period is 2**rateSel cycles
  typedef logic [1:0] rateSel_t;

  // Diagnostic function classes 00x, 04x and 10x
  typedef enum logic [1:0] {
    ctlFunc  = 2'd0,
    ldFunc   = 2'd1,
    readFunc = 2'd2
  } diagClass_e;

  typedef enum logic [1:0] {
    gateStopped = 2'd0,
    gateRunning = 2'd1,
    gateBurst   = 2'd2,
    gateStep    = 2'd3
  } gateState_e;

  typedef struct packed {
    diagClass_e cmdClass;
    diagSel_t   sel;
    ebusData_t  data;
  } diagCmd_s;

  // One-cycle function strobes out of the decoder
  typedef struct packed {
    logic stop;
    logic start;
    logic singleStep;
    logic burst;
    logic setReset;
    logic clrReset;
    logic ldBurstLo;
    logic ldBurstHi;
    logic ldRate;
    logic ldDisable;
  } funcStrobe_s;

  typedef struct packed {
    logic        mrReset;
    logic        runActive;
    logic        burstActive;
    rateSel_t    rateSel;
    logic        crmDis;
    logic        edpDis;
    logic        ctlDis;
    burstCount_t burstCount;
  } clkStatus_s;

  // Control function codes, class 00x
  localparam diagSel_t ctlStop       = 3'b000;
  localparam diagSel_t ctlStart      = 3'b001;
  localparam diagSel_t ctlSingleStep = 3'b010;
  localparam diagSel_t ctlBurst      = 3'b101;
  localparam diagSel_t ctlSetReset   = 3'b111;
  localparam diagSel_t ctlClrReset   = 3'b110;

  // Load function codes, class 04x
  localparam diagSel_t ldBurstLoSel = 3'd2;
  localparam diagSel_t ldBurstHiSel = 3'd3;
  localparam diagSel_t ldRateSel    = 3'd4;
  localparam diagSel_t ldDisableSel = 3'd5;

endpackage

// File: hw/mboxClkTop.sv
`timescale 1ns/1ns

module mboxClkTop import mboxClkPkg::*; (
  input  logic      MBOX_CLK,
  input  logic      CLK,
  input  diagCmd_s  cmd,
  input  logic      cmdValid,
  output logic      cmdReady,
  output ebusData_t rspData,
  output logic      rspValid,
  input  logic      rspReady,
  output logic      crmClkEn,
  output logic      edpClkEn,
  output logic      ctlClkEn,
  output logic      mrReset
);

  funcStrobe_s strobe;
  ebusData_t   ldData;
  logic        readReq;
  diagSel_t    readSel;
  logic        pulse;
  logic        burstZero;
  // Each block drives its own fields
  wire clkStatus_s status;

  assign status.mrReset = mrReset;

  diagFuncDecoder decoder (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .cmd      (cmd),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .rspBusy  (rspValid),
    .strobe   (strobe),
    .ldData   (ldData),
    .readReq  (readReq),
    .readSel  (readSel)
  );

  clkConfigRegs configRegs (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .strobe   (strobe),
    .ldData   (ldData),
    .rateSel  (status.rateSel),
    .crmDis   (status.crmDis),
    .edpDis   (status.edpDis),
    .ctlDis   (status.ctlDis)
  );

  burstCounter counter (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .strobe     (strobe),
    .ldData     (ldData),
    .pulse      (pulse),
    .burstCount (status.burstCount),
    .burstZero  (burstZero)
  );

  eboxClkGate gate (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .strobe      (strobe),
    .rateSel     (status.rateSel),
    .crmDis      (status.crmDis),
    .edpDis      (status.edpDis),
    .ctlDis      (status.ctlDis),
    .burstZero   (burstZero),
    .pulse       (pulse),
    .crmClkEn    (crmClkEn),
    .edpClkEn    (edpClkEn),
    .ctlClkEn    (ctlClkEn),
    .runActive   (status.runActive),
    .burstActive (status.burstActive),
    .mrReset     (mrReset)
  );

  diagReadback readback (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .readReq  (readReq),
    .readSel  (readSel),
    .status   (status),
    .rspData  (rspData),
    .rspValid (rspValid),
    .rspReady (rspReady)
  );

endmodule

// File: list.f
hw/mboxClkPkg.sv
hw/diagFuncDecoder.sv
hw/clkConfigRegs.sv
hw/burstCounter.sv
hw/eboxClkGate.sv
hw/diagReadback.sv
hw/mboxClkTop.sv
verif/mboxClkSva.sv
verif/mboxClkTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module mboxClkTb -o mboxClkSim
./obj_dir/mboxClkSim | tee sim.log

grep -qx "Regression passed" sim.log
echo "Simulation log shows a pass"

// File: verif/mboxClkStimulus.txt
// op cls sel data exp0 exp1 exp2, all hex; cls 0 control, 1 load, 2 read
// op 0 command, 1 read (exp0 word), 2 count pulses (exp0..2 CRM EDP CTL), 3 wait data cycles, 4 mark
1 2 0 00 20 00 00
1 2 2 00 00 00 00
1 2 1 00 00 00 00
0 0 6 00 00 00 00
1 2 0 00 00 00 00
0 0 7 00 00 00 00
1 2 0 00 20 00 00
0 0 6 00 00 00 00
0 1 3 0a 00 00 00
0 1 2 06 00 00 00
0 1 4 02 00 00 00
0 1 5 05 00 00 00
0 1 6 3f 00 00 00
0 0 3 00 00 00 00
0 0 4 00 00 00 00
1 2 0 00 02 00 00
1 2 1 00 29 00 00
1 2 2 00 25 00 00
0 1 3 00 00 00 00
0 1 2 05 00 00 00
4 0 0 00 00 00 00
0 0 5 00 00 00 00
2 0 0 00 00 05 00
1 2 0 00 02 00 00
1 2 1 00 00 00 00
1 2 2 00 05 00 00
0 1 4 00 00 00 00
0 1 5 02 00 00 00
0 1 2 03 00 00 00
0 1 3 01 00 00 00
4 0 0 00 00 00 00
0 0 5 00 00 00 00
2 0 0 00 13 00 13
1 2 2 00 02 00 00
1 2 0 00 00 00 00
0 1 4 03 00 00 00
0 1 5 00 00 00 00
0 1 2 07 00 00 00
4 0 0 00 00 00 00
0 0 5 00 00 00 00
2 0 0 00 07 07 07
1 2 0 00 03 00 00
1 2 1 00 00 00 00
4 0 0 00 00 00 00
0 0 5 00 00 00 00
2 0 0 00 00 00 00
0 1 4 01 00 00 00
4 0 0 00 00 00 00
0 0 2 00 00 00 00
2 0 0 00 01 01 01
0 1 5 04 00 00 00
4 0 0 00 00 00 00
0 0 2 00 00 00 00
2 0 0 00 00 01 01
0 0 1 00 00 00 00
3 0 0 14 00 00 00
1 2 0 00 09 00 00
0 0 0 00 00 00 00
3 0 0 02 00 00 00
4 0 0 00 00 00 00
2 0 0 00 00 00 00
1 2 0 00 01 00 00
0 0 7 00 00 00 00
1 2 0 00 21 00 00

// File: verif/mboxClkSva.sv
`timescale 1ns/1ns

module mboxClkSva import mboxClkPkg::*; (
  input logic        MBOX_CLK,
  input logic        CLK,
  input logic        cmdReady,
  input logic        rspValid,
  input logic        rspReady,
  input ebusData_t   rspData,
  input logic        crmClkEn,
  input logic        edpClkEn,
  input logic        ctlClkEn,
  input logic        runActive,
  input logic        burstActive,
  input funcStrobe_s strobe
);

  logic anyClkEn;

  assign anyClkEn = crmClkEn | edpClkEn | ctlClkEn;

  // Held response keeps its word
  rspHold: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    rspValid && !rspReady |=> rspValid && $stable(rspData))
    else $error("Read response changed under back-pressure");

  // No command accepted while a word waits
  cmdBlocked: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    rspValid |-> !cmdReady)
    else $error("Command port ready while a response is pending");

  // Step pulse comes the cycle after its strobe
  gateQuiet: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    anyClkEn |-> runActive || burstActive || $past(strobe.singleStep))
    else $error("Clock enable seen while the gate is stopped");

  ctlOneHot: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    $onehot0({strobe.stop, strobe.start, strobe.singleStep,
              strobe.burst, strobe.setReset, strobe.clrReset}))
    else $error("More than one control strobe in a cycle");

endmodule

bind mboxClkTop mboxClkSva sva (
  .MBOX_CLK    (MBOX_CLK),
  .CLK         (CLK),
  .cmdReady    (cmdReady),
  .rspValid    (rspValid),
  .rspReady    (rspReady),
  .rspData     (rspData),
  .crmClkEn    (crmClkEn),
  .edpClkEn    (edpClkEn),
  .ctlClkEn    (ctlClkEn),
  .runActive   (status.runActive),
  .burstActive (status.burstActive),
  .strobe      (strobe)
);

// File: verif/mboxClkTb.sv
`timescale 1ns/1ns

module mboxClkTb import mboxClkPkg::*;;

  localparam int cyclesPerLine = 300;
  localparam logic [31:0] lfsrSeed = 32'h1cdb9708;
  // Longest gap between pulses is 8 cycles
  localparam int idleCycles = 16;

  // One parsed stimulus line
  typedef struct packed {
    logic [3:0] op;
    logic [1:0] cls;
    diagSel_t   sel;
    ebusData_t  data;
    logic [7:0] exp0;
    logic [7:0] exp1;
    logic [7:0] exp2;
  } stimLine_s;

  logic      MBOX_CLK = 1'b0;
  logic      CLK;
  diagCmd_s  cmd;
  logic      cmdValid;
  logic      cmdReady;
  ebusData_t rspData;
  logic      rspValid;
  logic      rspReady;
  logic      crmClkEn;
  logic      edpClkEn;
  logic      ctlClkEn;
  logic      mrReset;

  stimLine_s   stim[$];
  logic [31:0] lfsr;
  int valueErrors = 0;
  int otherErrors = 0;
  int timeoutErrors = 0;
  int cycleCount = 0;
  int cycleLimit = 0;
  // Running pulse totals and their last checkpoint
  int crmTotal = 0;
  int edpTotal = 0;
  int ctlTotal = 0;
  int crmBase = 0;
  int edpBase = 0;
  int ctlBase = 0;

  mboxClkTop dut (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .cmd      (cmd),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .rspData  (rspData),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .crmClkEn (crmClkEn),
    .edpClkEn (edpClkEn),
    .ctlClkEn (ctlClkEn),
    .mrReset  (mrReset)
  );

  // 4 ns period
  always #2 MBOX_CLK = ~MBOX_CLK;

  // Pulse totals per EBOX clock group
  always @(posedge MBOX_CLK) begin
    if (!CLK) begin
      crmTotal <= crmTotal + int'(crmClkEn);
      edpTotal <= edpTotal + int'(edpClkEn);
      ctlTotal <= ctlTotal + int'(ctlClkEn);
    end
  end

  // Watchdog with its limit set once the stimulus is loaded
  always @(posedge MBOX_CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      timeoutErrors = timeoutErrors + 1;
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      endRun();
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic takeBit(output logic b);
    lfsr = lfsrStep(lfsr);
    b = lfsr[0];
  endtask

  task automatic endRun();
    $display("Errors: value %0d, other %0d, timeout %0d",
             valueErrors, otherErrors, timeoutErrors);
    if (valueErrors + otherErrors + timeoutErrors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic loadStimulus();
    int fd;
    int n;
    string text;
    int op;
    int cls;
    int sel;
    int data;
    int e0;
    int e1;
    int e2;
    stimLine_s entry;
    fd = $fopen("verif/mboxClkStimulus.txt", "r");
    if (fd == 0) begin
      otherErrors++;
      $display("Stimulus file verif/mboxClkStimulus.txt could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(text, fd);
      // Comment lines match no field
      n = $sscanf(text, "%h %h %h %h %h %h %h", op, cls, sel, data, e0, e1, e2);
      if (n == 7) begin
        entry.op   = op[3:0];
        entry.cls  = cls[1:0];
        entry.sel  = sel[2:0];
        entry.data = data[5:0];
        entry.exp0 = e0[7:0];
        entry.exp1 = e1[7:0];
        entry.exp2 = e2[7:0];
        stim.push_back(entry);
      end
    end
    $fclose(fd);
    if (stim.size() == 0) begin
      otherErrors++;
      $display("Stimulus file holds no operation lines");
    end
  endtask

  // Starts and ends on a falling edge
  task automatic sendCmd(input diagClass_e cls, input diagSel_t sel, input ebusData_t data);
    @(negedge MBOX_CLK);
    cmd.cmdClass = cls;
    cmd.sel      = sel;
    cmd.data     = data;
    cmdValid     = 1'b1;
    while (!cmdReady) @(negedge MBOX_CLK);
    // Transfer on the next rising edge
    @(negedge MBOX_CLK);
    cmdValid = 1'b0;
  endtask

  task automatic readWord(input diagSel_t sel, input ebusData_t expWord);
    logic rdy;
    sendCmd(readFunc, sel, '0);
    takeBit(rdy);
    rspReady = rdy;
    // Random back-pressure until the word is taken
    while (!(rspValid && rspReady)) begin
      @(negedge MBOX_CLK);
      takeBit(rdy);
      rspReady = rdy;
    end
    readCheck: assert (rspData == expWord) else begin
      valueErrors++;
      $display("FAIL rspData select %0h: got %h expected %h", sel, rspData, expWord);
    end
    // MR RESET pin matches the top bit of status word 0
    if (sel == 3'd0) begin
      resetCheck: assert (mrReset == expWord[5]) else begin
        valueErrors++;
        $display("FAIL mrReset: got %h expected %h", mrReset, expWord[5]);
      end
    end
    @(negedge MBOX_CLK);
    rspReady = 1'b0;
    // Exactly one word per read
    onceCheck: assert (!rspValid) else begin
      otherErrors++;
      $display("Read response still valid after it was taken, select %0h", sel);
    end
  endtask

  task automatic markCounters();
    crmBase = crmTotal;
    edpBase = edpTotal;
    ctlBase = ctlTotal;
  endtask

  task automatic checkCount(input string name, input int got, input int expected);
    countCheck: assert (got == expected) else begin
      valueErrors++;
      $display("FAIL %s pulses: got %h expected %h", name, got, expected);
    end
  endtask

  task automatic countPulses(input logic [7:0] expCrm, input logic [7:0] expEdp,
                             input logic [7:0] expCtl);
    int quiet;
    quiet = 0;
    // Gate counts as idle after a long quiet stretch
    while (quiet < idleCycles) begin
      @(negedge MBOX_CLK);
      if (crmClkEn || edpClkEn || ctlClkEn) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    checkCount("crmClkEn", crmTotal - crmBase, int'(expCrm));
    checkCount("edpClkEn", edpTotal - edpBase, int'(expEdp));
    checkCount("ctlClkEn", ctlTotal - ctlBase, int'(expCtl));
    markCounters();
  endtask

  task automatic runLine(input stimLine_s s);
    case (s.op)
      4'h0: sendCmd(diagClass_e'(s.cls), s.sel, s.data);
      4'h1: readWord(s.sel, s.exp0[5:0]);
      4'h2: countPulses(s.exp0, s.exp1, s.exp2);
      4'h3: repeat (int'(s.data)) @(negedge MBOX_CLK);
      4'h4: markCounters();
      default: begin
        otherErrors++;
        $display("Unknown stimulus operation %0h", s.op);
      end
    endcase
  endtask

  initial begin
    CLK      = 1'b1;
    cmd      = '0;
    cmdValid = 1'b0;
    rspReady = 1'b0;
    lfsr     = lfsrSeed;
    loadStimulus();
    cycleLimit = stim.size() * cyclesPerLine;
    // Reset for 10 cycles and released off the active edge
    repeat (10) @(posedge MBOX_CLK);
    @(negedge MBOX_CLK);
    CLK = 1'b0;
    markCounters();
    foreach (stim[i]) runLine(stim[i]);
    endRun();
  end

endmodule
